/* verilog/core_pkg.sv */
// Shared types for the RV32I subset core (ALU ops, LUI/AUIPC, BEQ/BNE/BLTU)
// Opcodes outside opcode_e retire as no-ops that write nothing
package core_pkg;

    typedef logic [31:0] word_t;     // Data or address word
    typedef logic [4:0]  reg_idx_t;  // Architectural register number

    localparam word_t RESET_PC = 32'h0000_0000;

    // Major opcodes that decode understands
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_BRANCH = 7'b1100011
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_PASS_B  // LUI and no-ops
    } alu_op_e;

    typedef enum logic [1:0] {
        BR_NONE,
        BR_EQ,
        BR_NE,
        BR_LTU
    } branch_e;

    // Instruction formats, msb first
    typedef struct packed {
        logic [6:0] funct7;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        reg_idx_t   rd;
        logic [6:0] opcode;
    } r_fmt_s;

    typedef struct packed {
        logic [11:0] imm_11_0;
        reg_idx_t    rs1;
        logic [2:0]  funct3;
        reg_idx_t    rd;
        logic [6:0]  opcode;
    } i_fmt_s;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_s;

    typedef struct packed {
        logic [19:0] imm_31_12;
        reg_idx_t    rd;
        logic [6:0]  opcode;
    } u_fmt_s;

    // Same 32 bits, four views
    typedef union packed {
        r_fmt_s r;
        i_fmt_s i;
        b_fmt_s b;
        u_fmt_s u;
    } instr_u;

    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t instr;
    } fetch_to_dec_s;

    typedef struct packed {
        logic     valid;
        word_t    pc;
        reg_idx_t rd;
        logic     we;
        alu_op_e  alu_op;
        branch_e  branch;
        word_t    operand_a;
        word_t    operand_b;
        word_t    rs2_val;    // Branch compare operand
        word_t    br_offset;  // Sign-extended B immediate
    } dec_to_ex_s;

    typedef struct packed {
        logic     valid;
        word_t    pc;
        reg_idx_t rd;
        logic     we;
        word_t    result;
    } ex_to_res_s;

endpackage

/* verilog/core_stage_if.sv */
`timescale 1ns/1ps
// Bundles between the core stages, each signal has exactly one driver
// Stall in fetch_dec_if is already gated by flush

interface fetch_dec_if
    import core_pkg::*;
();
    fetch_to_dec_s payload;  // From fetch
    logic          stall;    // From decode, fetch holds PC and payload
    modport src (output payload, input stall);
    modport snk (input payload, output stall);
endinterface

interface dec_ex_if
    import core_pkg::*;
();
    dec_to_ex_s payload;
    modport src (output payload);
    modport snk (input payload);
endinterface

interface ex_res_if
    import core_pkg::*;
();
    ex_to_res_s payload;
    modport src (output payload);
    modport snk (input payload);
endinterface

// Two combinational read ports into the register file
interface reg_rd_if
    import core_pkg::*;
();
    reg_idx_t rs1_addr;
    reg_idx_t rs2_addr;
    word_t    rs1_data;
    word_t    rs2_data;
    modport req (output rs1_addr, output rs2_addr, input rs1_data, input rs2_data);
    modport rsp (input rs1_addr, input rs2_addr, output rs1_data, output rs2_data);
endinterface

/* verilog/core_fetch.sv */
`timescale 1ns/1ps
// IMEM_WORDS must be a power of two; PCs beyond the memory wrap to low words
// Load port may only be used while i_run is low
module core_fetch
    import core_pkg::*;
#(
    parameter int IMEM_WORDS = 1024
) (
    input  logic                          i_clk,
    input  logic                          i_rst_n,
    input  logic                          i_run,
    input  logic                          i_imem_we,
    input  logic [$clog2(IMEM_WORDS)-1:0] i_imem_addr,
    input  word_t                         i_imem_wdata,
    input  logic                          i_flush,
    input  word_t                         i_flush_target,
    fetch_dec_if.src                      fd
);

    localparam int AW = $clog2(IMEM_WORDS);  // Word address width

    word_t         imem [IMEM_WORDS];  // Contents come only from the load port
    word_t         pc_q;               // Step 1 PC
    logic [AW-1:0] pc_idx;

    assign pc_idx = pc_q[AW+1:2];  // Byte PC to word index

    // External load port
    always_ff @(posedge i_clk) begin
        if (i_imem_we) begin
            imem[i_imem_addr] <= i_imem_wdata;
        end
    end

    // Step 1: PC select
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            pc_q <= RESET_PC;
        end else if (!i_run) begin
            pc_q <= RESET_PC;           // Halted, park at start
        end else if (i_flush) begin
            pc_q <= i_flush_target;     // Branch redirect wins over stall
        end else if (!fd.stall) begin
            pc_q <= pc_q + 32'd4;
        end
    end

    // Step 2: registered memory read
    // The word leaving here lines up with the PC it was read from
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            fd.payload.valid <= 1'b0;
        end else if (i_flush) begin
            fd.payload.valid <= 1'b0;   // Word being read is on the wrong path
        end else if (!fd.stall) begin
            fd.payload.valid <= i_run;  // Nothing issued while halted
            fd.payload.pc    <= pc_q;
            fd.payload.instr <= imem[pc_idx];
        end
    end

endmodule

/* verilog/core_decode.sv */
`timescale 1ns/1ps
// No bypass network; any source matching a pending write in execute or result stalls
// Stall is held off during a flush, so the two never act together
module core_decode
    import core_pkg::*;
(
    input  logic     i_clk,
    input  logic     i_rst_n,
    input  logic     i_flush,
    fetch_dec_if.snk fd,
    reg_rd_if.req    rf,
    dec_ex_if.src    dx,
    input  reg_idx_t i_ex_rd,   // Item now in execute
    input  logic     i_ex_we,
    input  reg_idx_t i_res_rd,  // Item now in result
    input  logic     i_res_we
);

    instr_u   iw;
    word_t    imm_i;
    word_t    imm_b;
    word_t    imm_u;
    alu_op_e  alu_op;
    branch_e  branch;
    logic     we;
    logic     use_rs1;
    logic     use_rs2;
    word_t    op_a;
    word_t    op_b;
    logic     hazard;

    // True when a used source waits on a pending destination, x0 excluded
    function automatic logic clash(reg_idx_t src, logic used, reg_idx_t dst, logic dst_we);
        return used && dst_we && (dst != '0) && (dst == src);
    endfunction

    assign iw    = fd.payload.instr;
    assign imm_i = {{20{iw.i.imm_11_0[11]}}, iw.i.imm_11_0};
    assign imm_b = {{19{iw.b.imm_12}}, iw.b.imm_12, iw.b.imm_11, iw.b.imm_10_5,
                    iw.b.imm_4_1, 1'b0};
    assign imm_u = {iw.u.imm_31_12, 12'h000};

    // Register file read, same field position in every format
    assign rf.rs1_addr = iw.r.rs1;
    assign rf.rs2_addr = iw.r.rs2;

    always_comb begin
        alu_op  = ALU_PASS_B;   // Default is a no-op
        branch  = BR_NONE;
        we      = 1'b0;
        use_rs1 = 1'b0;
        use_rs2 = 1'b0;
        op_a    = rf.rs1_data;
        op_b    = imm_i;
        case (iw.r.opcode)
            OPC_OP: begin
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                op_b    = rf.rs2_data;
                we      = 1'b1;
                case (iw.r.funct3)
                    3'b000:  alu_op = iw.r.funct7[5] ? ALU_SUB : ALU_ADD;
                    3'b100:  alu_op = ALU_XOR;
                    3'b110:  alu_op = ALU_OR;
                    3'b111:  alu_op = ALU_AND;
                    default: we = 1'b0;        // Shifts and compares unsupported
                endcase
            end
            OPC_OP_IMM: begin
                use_rs1 = 1'b1;
                we      = 1'b1;
                case (iw.i.funct3)
                    3'b000:  alu_op = ALU_ADD;
                    3'b100:  alu_op = ALU_XOR;
                    3'b110:  alu_op = ALU_OR;
                    3'b111:  alu_op = ALU_AND;
                    default: we = 1'b0;
                endcase
            end
            OPC_LUI: begin
                op_b = imm_u;   // Passed straight through
                we   = 1'b1;
            end
            OPC_AUIPC: begin
                op_a   = fd.payload.pc;
                op_b   = imm_u;
                alu_op = ALU_ADD;
                we     = 1'b1;
            end
            OPC_BRANCH: begin
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                op_b    = rf.rs2_data;
                case (iw.b.funct3)
                    3'b000:  branch = BR_EQ;
                    3'b001:  branch = BR_NE;
                    3'b110:  branch = BR_LTU;
                    default: branch = BR_NONE;  // Other compares act as no-ops
                endcase
            end
            default: ;  // Unknown opcode, retires with no write
        endcase
    end

    assign hazard = clash(iw.r.rs1, use_rs1, i_ex_rd, i_ex_we)
                  | clash(iw.r.rs1, use_rs1, i_res_rd, i_res_we)
                  | clash(iw.r.rs2, use_rs2, i_ex_rd, i_ex_we)
                  | clash(iw.r.rs2, use_rs2, i_res_rd, i_res_we);

    assign fd.stall = fd.payload.valid && hazard && !i_flush;

    // Decode to execute register; bubble on stall, flush or empty slot
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            dx.payload.valid <= 1'b0;
            dx.payload.we    <= 1'b0;
        end else if (i_flush || fd.stall || !fd.payload.valid) begin
            dx.payload.valid <= 1'b0;
            dx.payload.we    <= 1'b0;  // Keeps the hazard check quiet
        end else begin
            dx.payload.valid     <= 1'b1;
            dx.payload.we        <= we;
            dx.payload.pc        <= fd.payload.pc;
            dx.payload.rd        <= iw.r.rd;
            dx.payload.alu_op    <= alu_op;
            dx.payload.branch    <= branch;
            dx.payload.operand_a <= op_a;
            dx.payload.operand_b <= op_b;
            dx.payload.rs2_val   <= rf.rs2_data;
            dx.payload.br_offset <= imm_b;
        end
    end

endmodule

/* verilog/core_execute.sv */
`timescale 1ns/1ps
// Flush and its target are combinational from the registered execute item
// A taken branch kills the two younger instructions in fetch and decode
module core_execute
    import core_pkg::*;
(
    input  logic   i_clk,
    input  logic   i_rst_n,
    dec_ex_if.snk  dx,
    ex_res_if.src  xr,
    output logic   o_flush,
    output word_t  o_flush_target
);

    word_t alu_res;
    logic  taken;
    word_t a;
    word_t b;

    assign a = dx.payload.operand_a;
    assign b = dx.payload.operand_b;

    // ALU, AUIPC arrives here with the PC already on operand A
    always_comb begin
        case (dx.payload.alu_op)
            ALU_ADD:    alu_res = a + b;
            ALU_SUB:    alu_res = a - b;  // Wraps modulo 2^32
            ALU_AND:    alu_res = a & b;
            ALU_OR:     alu_res = a | b;
            ALU_XOR:    alu_res = a ^ b;
            ALU_PASS_B: alu_res = b;      // LUI
            default:    alu_res = b;
        endcase
    end

    // Branch compare against the rs2 value
    always_comb begin
        case (dx.payload.branch)
            BR_EQ:   taken = (a == dx.payload.rs2_val);
            BR_NE:   taken = (a != dx.payload.rs2_val);
            BR_LTU:  taken = (a < dx.payload.rs2_val);   // Unsigned
            default: taken = 1'b0;
        endcase
    end

    // Only a live branch redirects
    assign o_flush        = dx.payload.valid && taken;
    assign o_flush_target = dx.payload.pc + dx.payload.br_offset;

    // Execute to result register
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            xr.payload.valid <= 1'b0;
            xr.payload.we    <= 1'b0;
        end else begin
            xr.payload.valid  <= dx.payload.valid;
            xr.payload.we     <= dx.payload.valid && dx.payload.we;  // Bubbles never write
            xr.payload.pc     <= dx.payload.pc;
            xr.payload.rd     <= dx.payload.rd;
            xr.payload.result <= alu_res;
        end
    end

endmodule

/* verilog/core_result.sv */
`timescale 1ns/1ps
// Register file is written from the retire register, reads see that write in the same cycle
// x0 reads as zero; a write to x0 is still reported with we high
module core_result
    import core_pkg::*;
(
    input  logic     i_clk,
    input  logic     i_rst_n,
    ex_res_if.snk    xr,
    reg_rd_if.rsp    rf,
    output logic     o_retire_valid,
    output word_t    o_retire_pc,
    output reg_idx_t o_retire_rd,
    output logic     o_retire_we,
    output word_t    o_retire_data
);

    word_t regs [1:31];  // x1..x31
    logic  wr_en;

    // Zero for x0, write-through on a matching write, else the stored value
    function automatic word_t read_port(reg_idx_t idx, word_t stored, logic wen,
                                        reg_idx_t widx, word_t wdata);
        if (idx == '0) begin
            return '0;
        end
        if (wen && (widx == idx)) begin
            return wdata;
        end
        return stored;
    endfunction

    assign wr_en = o_retire_valid && o_retire_we && (o_retire_rd != '0);

    assign rf.rs1_data = read_port(rf.rs1_addr, regs[rf.rs1_addr], wr_en,
                                   o_retire_rd, o_retire_data);
    assign rf.rs2_data = read_port(rf.rs2_addr, regs[rf.rs2_addr], wr_en,
                                   o_retire_rd, o_retire_data);

    // Retire report, one cycle per valid item
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_retire_valid <= 1'b0;
            o_retire_we    <= 1'b0;
        end else begin
            o_retire_valid <= xr.payload.valid;
            o_retire_we    <= xr.payload.we;
            o_retire_pc    <= xr.payload.pc;
            o_retire_rd    <= xr.payload.rd;
            o_retire_data  <= xr.payload.result;
        end
    end

    // Write-back lands at the end of the retire cycle
    always_ff @(posedge i_clk) begin
        if (wr_en) begin
            regs[o_retire_rd] <= o_retire_data;
        end
    end

endmodule

/* verilog/core_top.sv */
`timescale 1ns/1ps
// Four-stage RV32I subset core, program loaded through the imem port while i_run is low
// Each retired instruction shows up once on the o_retire_* ports
module core_top
    import core_pkg::*;
#(
    parameter int IMEM_WORDS = 1024
) (
    input  logic                          i_clk,
    input  logic                          i_rst_n,
    input  logic                          i_imem_we,
    input  logic [$clog2(IMEM_WORDS)-1:0] i_imem_addr,  // Word index
    input  word_t                         i_imem_wdata,
    input  logic                          i_run,
    output logic                          o_retire_valid,
    output word_t                         o_retire_pc,
    output reg_idx_t                      o_retire_rd,
    output logic                          o_retire_we,
    output word_t                         o_retire_data
);

    fetch_dec_if u_fd_if ();
    dec_ex_if    u_dx_if ();
    ex_res_if    u_xr_if ();
    reg_rd_if    u_rf_if ();

    logic  flush;         // Taken branch in execute
    word_t flush_target;

    core_fetch #(
        .IMEM_WORDS (IMEM_WORDS)
    ) u_fetch (
        .i_clk, .i_rst_n, .i_run,
        .i_imem_we, .i_imem_addr, .i_imem_wdata,
        .i_flush        (flush),
        .i_flush_target (flush_target),
        .fd             (u_fd_if.src)
    );

    // Pending destinations come from the execute and result stage registers
    core_decode u_decode (
        .i_clk, .i_rst_n,
        .i_flush  (flush),
        .fd       (u_fd_if.snk),
        .rf       (u_rf_if.req),
        .dx       (u_dx_if.src),
        .i_ex_rd  (u_dx_if.payload.rd),
        .i_ex_we  (u_dx_if.payload.we),
        .i_res_rd (u_xr_if.payload.rd),
        .i_res_we (u_xr_if.payload.we)
    );

    core_execute u_execute (
        .i_clk, .i_rst_n,
        .dx             (u_dx_if.snk),
        .xr             (u_xr_if.src),
        .o_flush        (flush),
        .o_flush_target (flush_target)
    );

    core_result u_result (
        .i_clk, .i_rst_n,
        .xr (u_xr_if.snk),
        .rf (u_rf_if.rsp),
        .o_retire_valid, .o_retire_pc, .o_retire_rd, .o_retire_we, .o_retire_data
    );

endmodule

/* test/tb_core_assert.sv */
`timescale 1ns/1ps
// Bound into core_decode; watches the fetch payload, stall, flush and the decode output
module tb_core_assert (
    input logic        i_clk,
    input logic        i_rst_n,
    input logic        i_flush,
    input logic        i_stall,
    input logic        i_fd_valid,
    input logic [31:0] i_fd_pc,
    input logic [31:0] i_fd_instr,
    input logic        i_dx_valid
);

    // A taken branch empties the fetch slot even when decode would stall
    a_flush_vs_stall: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_flush |=> !i_fd_valid)
        else $error("flush did not empty the fetch slot, the stall held it");

    // Nothing leaves decode in the two cycles after a reset
    a_reset_quiet: assert property (@(posedge i_clk)
        !i_rst_n |=> !i_dx_valid ##1 !i_dx_valid)
        else $error("decode output valid right after reset");

    a_stall_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_stall |=> $stable(i_fd_valid) && $stable(i_fd_pc) && $stable(i_fd_instr))
        else $error("fetch payload changed while stalled");

endmodule

/* test/tb_core_checker.sv */
`timescale 1ns/1ps
// Compares each retire with the next queued expectation, sampled on the falling edge
// Data and rd are compared only for instructions expected to write
module tb_core_checker (
    input logic        i_clk,
    input logic        i_rst_n,
    input logic        i_run,
    input logic        i_retire_valid,
    input logic [31:0] i_retire_pc,
    input logic [4:0]  i_retire_rd,
    input logic        i_retire_we,
    input logic [31:0] i_retire_data
);

    logic [31:0] exp_pc[$];
    logic [4:0]  exp_rd[$];
    bit          exp_we[$];
    logic [31:0] exp_data[$];

    int check_count = 0;
    int error_count = 0;
    bit started     = 0;   // i_run seen high
    bit done        = 0;

    task automatic expect_retire(logic [31:0] pc, logic [4:0] rd, bit we, logic [31:0] data);
        exp_pc.push_back(pc);
        exp_rd.push_back(rd);
        exp_we.push_back(we);
        exp_data.push_back(data);
    endtask

    always @(posedge i_clk) begin
        if (i_run) begin
            started <= 1;
        end
    end

    always @(negedge i_clk) begin
        logic [31:0] pc;
        logic [4:0]  rd;
        bit          we;
        logic [31:0] data;
        bit          bad;
        if (i_rst_n && i_retire_valid) begin
            if (!started) begin
                $display("Retire seen at pc %h while the core was halted", i_retire_pc);
                error_count++;
            end else if (exp_pc.size() == 0) begin
                $display("Unexpected retire at pc %h after the program ended", i_retire_pc);
                error_count++;
            end else begin
                pc   = exp_pc.pop_front();
                rd   = exp_rd.pop_front();
                we   = exp_we.pop_front();
                data = exp_data.pop_front();
                bad  = 0;
                if (i_retire_pc !== pc) begin
                    $display("FAILED o_retire_pc: got %h expected %h", i_retire_pc, pc);
                    bad = 1;
                end
                if (i_retire_we !== we) begin
                    $display("FAILED o_retire_we: got %h expected %h", i_retire_we, we);
                    bad = 1;
                end
                if (we && i_retire_rd !== rd) begin
                    $display("FAILED o_retire_rd: got %h expected %h", i_retire_rd, rd);
                    bad = 1;
                end
                if (we && i_retire_data !== data) begin
                    $display("FAILED o_retire_data: got %h expected %h", i_retire_data, data);
                    bad = 1;
                end
                if (bad) begin
                    error_count++;
                end else begin
                    $display("ok   retire pc %h rd x%0d we %0d data %h", pc, rd, we,
                             i_retire_data);
                end
                check_count++;
                if (exp_pc.size() == 0) begin
                    done = 1;
                end
            end
        end
    end

endmodule

/* test/tb_core.sv */
`timescale 1ns/1ps
// Runs one hand-coded RV32I program and compares every retire with a table
// The last row is a branch to itself, so reset stops the core once the table is used up
module tb_core;

    localparam int IMEM_WORDS = 64;
    localparam int CLK_PERIOD = 100;
    localparam int PAD_WORDS  = 2;   // Fetched behind the final loop, always flushed

    typedef struct {
        logic [31:0] word;
        bit          retires;
        logic [4:0]  rd;
        bit          we;
        logic [31:0] data;
    } row_t;

    logic        clk;
    logic        rst_n;
    logic        imem_we;
    logic [5:0]  imem_addr;
    logic [31:0] imem_wdata;
    logic        run;
    logic        retire_valid;
    logic [31:0] retire_pc;
    logic [4:0]  retire_rd;
    logic        retire_we;
    logic [31:0] retire_data;

    row_t rows[$];
    int   n_retiring;
    bit   table_ready;

    core_top #(
        .IMEM_WORDS (IMEM_WORDS)
    ) UUT (
        .i_clk          (clk),
        .i_rst_n        (rst_n),
        .i_imem_we      (imem_we),
        .i_imem_addr    (imem_addr),
        .i_imem_wdata   (imem_wdata),
        .i_run          (run),
        .o_retire_valid (retire_valid),
        .o_retire_pc    (retire_pc),
        .o_retire_rd    (retire_rd),
        .o_retire_we    (retire_we),
        .o_retire_data  (retire_data)
    );

    tb_core_checker u_checker (
        .i_clk          (clk),
        .i_rst_n        (rst_n),
        .i_run          (run),
        .i_retire_valid (retire_valid),
        .i_retire_pc    (retire_pc),
        .i_retire_rd    (retire_rd),
        .i_retire_we    (retire_we),
        .i_retire_data  (retire_data)
    );

    bind core_decode tb_core_assert u_assert (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_flush    (i_flush),
        .i_stall    (fd.stall),
        .i_fd_valid (fd.payload.valid),
        .i_fd_pc    (fd.payload.pc),
        .i_fd_instr (fd.payload.instr),
        .i_dx_valid (dx.payload.valid)
    );

    // RV32I encoders, field order per the ISA manual
    function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3, logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1,
                                          logic [2:0] f3, logic [4:0] rd);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] enc_u(logic [19:0] imm, logic [4:0] rd, logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] enc_b(logic [12:0] off, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    task automatic add_row(logic [31:0] word, bit retires, logic [4:0] rd, bit we,
                           logic [31:0] data);
        row_t r;
        r.word    = word;
        r.retires = retires;
        r.rd      = rd;
        r.we      = we;
        r.data    = data;
        rows.push_back(r);
    endtask

    // Row index times 4 is the PC; expected data worked out by hand
    task automatic build_program();
        add_row(enc_i(12'd5, 0, 3'b000, 1), 1, 1, 1, 32'h0000_0005);        // ADDI x1
        add_row(enc_i(12'd3, 0, 3'b000, 2), 1, 2, 1, 32'h0000_0003);        // ADDI x2
        add_row(enc_r(7'h20, 1, 2, 3'b000, 3), 1, 3, 1, 32'hffff_fffe);     // SUB wraps
        add_row(enc_r(7'h00, 1, 3, 3'b111, 4), 1, 4, 1, 32'h0000_0004);     // AND
        add_row(enc_r(7'h00, 2, 4, 3'b110, 5), 1, 5, 1, 32'h0000_0007);     // OR
        add_row(enc_r(7'h00, 1, 5, 3'b100, 6), 1, 6, 1, 32'h0000_0002);     // XOR
        add_row(enc_i(12'h0ff, 6, 3'b100, 7), 1, 7, 1, 32'h0000_00fd);      // XORI
        add_row(enc_i(12'h100, 7, 3'b110, 8), 1, 8, 1, 32'h0000_01fd);      // ORI
        add_row(enc_i(12'h0f0, 8, 3'b111, 9), 1, 9, 1, 32'h0000_00f0);      // ANDI
        add_row(enc_u(20'h12345, 10, 7'b0110111), 1, 10, 1, 32'h1234_5000); // LUI
        add_row(enc_u(20'h00001, 11, 7'b0010111), 1, 11, 1, 32'h0000_1028); // AUIPC at 40
        add_row(enc_b(13'd12, 1, 1, 3'b000), 1, 0, 0, 0);                   // BEQ taken to 56
        add_row(enc_i(12'd1, 0, 3'b000, 12), 0, 12, 1, 32'h1);              // Skipped
        add_row(enc_i(12'd2, 0, 3'b000, 12), 0, 12, 1, 32'h2);              // Skipped
        add_row(enc_b(13'd8, 1, 1, 3'b001), 1, 0, 0, 0);                    // BNE not taken
        add_row(enc_b(13'd12, 1, 2, 3'b110), 1, 0, 0, 0);                   // BLTU 3<5 to 72
        add_row(enc_i(12'd7, 0, 3'b000, 13), 0, 13, 1, 32'h7);              // Skipped
        add_row(enc_i(12'd8, 0, 3'b000, 13), 0, 13, 1, 32'h8);              // Skipped
        add_row(enc_i(12'd9, 0, 3'b000, 0), 1, 0, 1, 32'h0000_0009);        // Write to x0
        add_row(enc_r(7'h00, 1, 0, 3'b000, 14), 1, 14, 1, 32'h0000_0005);   // x0 reads zero
        add_row(enc_i(12'hfff, 14, 3'b000, 15), 1, 15, 1, 32'h0000_0004);   // ADDI -1
        add_row(enc_b(13'd0, 0, 0, 3'b000), 1, 0, 0, 0);                    // Loop on itself
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Watchdog, eight cycles per row plus slack
    initial begin
        wait (table_ready);
        #((rows.size() * 8 + 20) * CLK_PERIOD);
        $display("Timeout: the program did not retire all expected instructions in time");
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        rst_n       = 1'b0;
        run         = 1'b0;
        imem_we     = 1'b0;
        imem_addr   = '0;
        imem_wdata  = '0;
        n_retiring  = 0;
        table_ready = 0;
        build_program();
        table_ready = 1;

        repeat (2) @(negedge clk);
        rst_n = 1'b1;

        // Load memory and queue expected retires with the core halted
        for (int i = 0; i < rows.size(); i++) begin
            @(negedge clk);
            imem_we    = 1'b1;
            imem_addr  = 6'(i);
            imem_wdata = rows[i].word;
            if (rows[i].retires) begin
                u_checker.expect_retire(32'(i * 4), rows[i].rd, rows[i].we, rows[i].data);
                n_retiring++;
            end
        end
        for (int i = 0; i < PAD_WORDS; i++) begin
            @(negedge clk);
            imem_addr  = 6'(rows.size() + i);
            imem_wdata = enc_i(12'd0, 0, 3'b000, 0);   // NOP
        end
        @(negedge clk);
        imem_we = 1'b0;
        repeat (3) @(negedge clk);   // Idle while halted, nothing may retire
        run = 1'b1;

        wait (u_checker.done);
        @(negedge clk);
        rst_n = 1'b0;   // Stop the final loop
        run   = 1'b0;
        repeat (2) @(negedge clk);

        $display("Checked %0d of %0d retires, %0d errors", u_checker.check_count,
                 n_retiring, u_checker.error_count);
        if (u_checker.error_count == 0 && u_checker.check_count == n_retiring) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* compile.f */
verilog/core_pkg.sv
verilog/core_stage_if.sv
verilog/core_fetch.sv
verilog/core_decode.sv
verilog/core_execute.sv
verilog/core_result.sv
verilog/core_top.sv
test/tb_core_assert.sv
test/tb_core_checker.sv
test/tb_core.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_core
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SIM = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "^TEST PASS$$"

clean:
	rm -rf $(OBJ_DIR)
